//--- hdl/stream_pkg.sv
////////////////////////////////////////
// shared widths and host register map for the
// write-only stream bridge
// imported by wildcard in each module header,
// top level passes data_w / addr_bit down
////////////////////////////////////////

package stream_pkg;

    ////////////////////////////////////////
    // default widths

    localparam int DATA_W   = 32;           // data word, also data_w default
    localparam int ADDR_BIT = 4;            // fifo address bits, depth 16
    localparam int WB_ADR_W = 8;            // both wishbone address buses

    ////////////////////////////////////////
    // host register map

    // push register, every write here is one stream word
    localparam logic [WB_ADR_W-1:0] REG_DATA   = 8'h00;

    // status register, fill count and full flag
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 8'h01;

    ////////////////////////////////////////
    // status word layout

    // fill count sits in the low bits [ADDR_BIT:0]
    localparam int STAT_FULL_BIT = DATA_W - 1;  // full flag, top bit of word

endpackage : stream_pkg

//--- hdl/reg_fifo.sv
////////////////////////////////////////
// register array fifo with registered output word
// depth is 2**addr_bit in memory plus one word
// held in dout, level counts the memory only
// dout_valid marks dout as the oldest word
////////////////////////////////////////

`timescale 1ns/100ps

module reg_fifo
    import stream_pkg::*;
#(
    parameter int data_w   = DATA_W,
    parameter int addr_bit = ADDR_BIT
)
(
    input  logic                clk,
    input  logic                rst,
    // write side
    input  logic                push,
    input  logic [data_w-1:0]   push_data,
    output logic                full,
    output logic [addr_bit:0]   level,
    // read side
    input  logic                pop,
    output logic                dout_valid,
    output logic [data_w-1:0]   dout
);

    localparam int depth = 2 ** addr_bit;

    logic [data_w-1:0]      mem [depth];    // register array
    logic [addr_bit-1:0]    wr_ptr;
    logic [addr_bit-1:0]    rd_ptr;
    logic [addr_bit:0]      count;          // words in mem
    logic                   mem_nempty;
    logic                   wr_en;
    logic                   ld_en;          // mem -> dout transfer

    assign full       = count[addr_bit];    // msb set only at depth
    assign level      = count;
    assign mem_nempty = (count != '0);
    assign wr_en      = push & ~full;       // push on full is dropped

    // refill dout when it is empty or being taken
    assign ld_en      = mem_nempty & (~dout_valid | pop);

    // oldest word, count back from write pointer
    assign rd_ptr     = wr_ptr - count[addr_bit-1:0];

    ////////////////////////////////////////
    // memory and pointers

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wr_ptr <= '0;
        else if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;        // wraps at depth
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else
        begin
            case ({ld_en, wr_en})
                2'b01:   count <= count + 1'b1;
                2'b10:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    ////////////////////////////////////////
    // output stage

    always_ff @(posedge clk)
    begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= (dout_valid & ~pop) | mem_nempty;
    end

    always_ff @(posedge clk)
    begin
        if (ld_en)
            dout <= mem[rd_ptr];
    end

endmodule : reg_fifo

//--- hdl/wb_push_port.sv
////////////////////////////////////////
// host side wishbone classic slave
// writes to REG_DATA push one word into the fifo,
// reads of REG_STATUS return fill count and full flag
// data writes are held off while the fifo is full
////////////////////////////////////////

`timescale 1ns/100ps

module wb_push_port
    import stream_pkg::*;
#(
    parameter int data_w   = DATA_W,
    parameter int addr_bit = ADDR_BIT
)
(
    input  logic                clk,
    input  logic                rst,
    // host wishbone slave
    input  logic                s_cyc,
    input  logic                s_stb,
    input  logic                s_we,
    input  logic [WB_ADR_W-1:0] s_adr,
    input  logic [data_w-1:0]   s_dat_w,
    output logic [data_w-1:0]   s_dat_r,
    output logic                s_ack,
    // fifo write side
    output logic                push,
    output logic [data_w-1:0]   push_data,
    input  logic                full,
    input  logic [addr_bit:0]   level
);

    logic               req;            // request not yet acked
    logic               data_wr;        // write to push register
    logic               stat_rd;        // read of status register
    logic               hold;           // back-pressure on host
    logic [data_w-1:0]  status_word;

    ////////////////////////////////////////
    // decode

    // ack gates req, so one request never gets two acks in a row
    assign req     = s_cyc & s_stb & ~s_ack;
    assign data_wr = s_we & (s_adr == REG_DATA);
    assign stat_rd = ~s_we & (s_adr == REG_STATUS);
    assign hold    = data_wr & full;    // wait for room

    always_comb
    begin
        status_word                = '0;
        status_word[addr_bit:0]    = level;     // fill count in low bits
        status_word[STAT_FULL_BIT] = full;
    end

    ////////////////////////////////////////
    // ack and push strobe

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_ack <= 1'b0;
            push  <= 1'b0;
        end
        else
        begin
            s_ack <= req & ~hold;                   // other addresses ack too
            push  <= req & data_wr & ~full;         // push lands in ack cycle
        end
    end

    // push data and read data
    always_ff @(posedge clk)
    begin
        if (req & data_wr)
            push_data <= s_dat_w;
        if (req & stat_rd)
            s_dat_r <= status_word;
        else
            s_dat_r <= '0;                  // other reads return zero
    end

endmodule : wb_push_port

//--- hdl/wb_drain_master.sv
////////////////////////////////////////
// downstream wishbone classic master
// writes each fifo word to the target at an
// incrementing address, pops on m_ack
// cycle stays open while words keep coming
////////////////////////////////////////

`timescale 1ns/100ps

module wb_drain_master
    import stream_pkg::*;
#(
    parameter int data_w = DATA_W
)
(
    input  logic                clk,
    input  logic                rst,
    // fifo read side
    input  logic                dout_valid,
    input  logic [data_w-1:0]   dout,
    output logic                pop,
    // target wishbone master
    output logic                m_cyc,
    output logic                m_stb,
    output logic                m_we,
    output logic [WB_ADR_W-1:0] m_adr,
    output logic [data_w-1:0]   m_dat_w,
    input  logic                m_ack
);

    logic active;       // dout_valid seen one clock earlier
    logic xfer;         // word accepted by target

    ////////////////////////////////////////
    // cycle control

    // start one clock after dout_valid rises
    always_ff @(posedge clk)
    begin
        if (rst)
            active <= 1'b0;
        else
            active <= dout_valid;
    end

    // drops with dout_valid once the last word is taken
    assign m_stb   = active & dout_valid;
    assign m_cyc   = m_stb;
    assign m_we    = m_stb;             // write only
    assign m_dat_w = dout;              // fifo output is already registered

    assign xfer = m_stb & m_ack;
    assign pop  = xfer;                 // fifo reloads dout on same edge

    ////////////////////////////////////////
    // target address

    always_ff @(posedge clk)
    begin
        if (rst)
            m_adr <= '0;
        else if (xfer)
            m_adr <= m_adr + 1'b1;      // wraps at 2**WB_ADR_W
    end

endmodule : wb_drain_master

//--- hdl/stream_bridge_top.sv
////////////////////////////////////////
// stream bridge top level
// host pushes over the slave port, words queue
// in the fifo, drain master writes them out
// data_w and addr_bit are set here only
////////////////////////////////////////

`timescale 1ns/100ps

module stream_bridge_top
    import stream_pkg::*;
#(
    parameter int data_w   = DATA_W,
    parameter int addr_bit = ADDR_BIT
)
(
    input  logic                clk,
    input  logic                rst,
    // host side slave
    input  logic                s_cyc,
    input  logic                s_stb,
    input  logic                s_we,
    input  logic [WB_ADR_W-1:0] s_adr,
    input  logic [data_w-1:0]   s_dat_w,
    output logic [data_w-1:0]   s_dat_r,
    output logic                s_ack,
    // downstream master
    output logic                m_cyc,
    output logic                m_stb,
    output logic                m_we,
    output logic [WB_ADR_W-1:0] m_adr,
    output logic [data_w-1:0]   m_dat_w,
    input  logic                m_ack
);

    ////////////////////////////////////////
    // internal links

    logic               push;
    logic [data_w-1:0]  push_data;
    logic               full;
    logic [addr_bit:0]  level;
    logic               pop;
    logic               dout_valid;
    logic [data_w-1:0]  dout;

    ////////////////////////////////////////
    // producer, buffer, consumer

    wb_push_port #(
        .data_w     (data_w),
        .addr_bit   (addr_bit)
    ) u_wb_push_port (
        .clk        (clk),
        .rst        (rst),
        .s_cyc      (s_cyc),
        .s_stb      (s_stb),
        .s_we       (s_we),
        .s_adr      (s_adr),
        .s_dat_w    (s_dat_w),
        .s_dat_r    (s_dat_r),
        .s_ack      (s_ack),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .level      (level)
    );

    reg_fifo #(
        .data_w     (data_w),
        .addr_bit   (addr_bit)
    ) u_reg_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .level      (level),
        .pop        (pop),
        .dout_valid (dout_valid),
        .dout       (dout)
    );

    wb_drain_master #(
        .data_w     (data_w)
    ) u_wb_drain_master (
        .clk        (clk),
        .rst        (rst),
        .dout_valid (dout_valid),
        .dout       (dout),
        .pop        (pop),
        .m_cyc      (m_cyc),
        .m_stb      (m_stb),
        .m_we       (m_we),
        .m_adr      (m_adr),
        .m_dat_w    (m_dat_w),
        .m_ack      (m_ack)
    );

endmodule : stream_bridge_top

//--- testbench/tb_clock_gen.sv
////////////////////////////////////////
// testbench clock and reset source
// free running clock, rst held high for the
// first rst_cycles rising edges, released low
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen
#(
    parameter int half_period = 10,     // 20 ns clock
    parameter int rst_cycles  = 5
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule : tb_clock_gen

//--- testbench/tb_stream_bridge.sv
////////////////////////////////////////
// testbench for the stream bridge
// plays the trace file as host traffic, models the
// downstream target with hold and random ack delay,
// checks order, data, addresses and status reads
////////////////////////////////////////

`timescale 1ns/100ps

module tb_stream_bridge
    import stream_pkg::*;
();

    logic                clk;
    logic                rst;
    logic                s_cyc;
    logic                s_stb;
    logic                s_we;
    logic [WB_ADR_W-1:0] s_adr;
    logic [DATA_W-1:0]   s_dat_w;
    logic [DATA_W-1:0]   s_dat_r;
    logic                s_ack;
    logic                m_cyc;
    logic                m_stb;
    logic                m_we;
    logic [WB_ADR_W-1:0] m_adr;
    logic [DATA_W-1:0]   m_dat_w;
    logic                m_ack = 1'b0;

    byte                 op_q[$];           // trace op letters
    logic [31:0]         a_q[$];
    logic [31:0]         b_q[$];
    logic [DATA_W-1:0]   exp_q[$];          // every acked push, in order
    logic [WB_ADR_W-1:0] exp_adr = '0;      // next target address
    int                  delivered = 0;     // words seen at target
    logic                sink_hold = 1'b0;
    int                  dly_min = 0;
    int                  dly_max = 0;
    int                  wait_left = -1;    // -1 means no delay picked yet
    int                  errors = 0;
    int                  checks = 0;
    int                  sink_errors = 0;   // target side counts
    int                  sink_checks = 0;
    int                  tests = 0;
    int                  test_err = 0;
    int                  cycles = 0;
    int                  limit = 0;

    tb_clock_gen u_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    stream_bridge_top #(
        .data_w   (DATA_W),
        .addr_bit (ADDR_BIT)
    ) u_stream_bridge_top (.*);

    ////////////////////////////////////////
    // helpers

    task automatic flag_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // one classic cycle, stall > 0 expects no ack for that many
    // cycles and then lets the sink go
    task automatic host_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                              input logic [DATA_W-1:0] wdata, input int stall,
                              output logic [DATA_W-1:0] rdata);
        @(negedge clk);
        s_cyc   = 1'b1;
        s_stb   = 1'b1;
        s_we    = we;
        s_adr   = adr;
        s_dat_w = wdata;
        repeat (stall)
        begin
            @(negedge clk);
            checks++;
            if (s_ack)
                flag_error("push acked while the fifo was full");
        end
        if (stall > 0)
            sink_hold <= 1'b0;              // drain resumes, room appears
        @(negedge clk);
        while (!s_ack)
            @(negedge clk);
        rdata = s_dat_r;                    // read data valid with ack
        s_cyc = 1'b0;
        s_stb = 1'b0;
        s_we  = 1'b0;
    endtask

    task automatic push_word(input logic [DATA_W-1:0] data, input int stall);
        logic [DATA_W-1:0] rd;
        host_cycle(1'b1, REG_DATA, data, stall, rd);
        exp_q.push_back(data);
    endtask

    task automatic read_status(input int count, input logic flag);
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp;
        repeat (3)
            @(negedge clk);                 // let the last push reach dout
        host_cycle(1'b0, REG_STATUS, '0, 0, rd);
        exp                = '0;
        exp[ADDR_BIT:0]    = count[ADDR_BIT:0];
        exp[STAT_FULL_BIT] = flag;
        checks++;
        if (rd != exp)
            flag_error($sformatf("status read %h, expected %h", rd, exp));
    endtask

    // delivered only changes on falling edges
    task automatic wait_drained();
        while (delivered < exp_q.size())
            @(posedge clk);
        @(negedge clk);
        checks++;
        if (m_cyc || m_stb)
            flag_error("target cycle still open after the last word");
    endtask

    task automatic close_test(input int id);
        tests++;
        $display("test %0d finished, %0d mismatches", id, errors + sink_errors - test_err);
        test_err = errors + sink_errors;
    endtask

    ////////////////////////////////////////
    // downstream target model

    always @(negedge clk)
    begin
        m_ack = 1'b0;
        if (!rst && m_stb && !sink_hold)
        begin
            if (wait_left < 0)
                wait_left = int'($urandom_range(dly_max, dly_min));
            if (wait_left == 0)
            begin
                m_ack     = 1'b1;           // word taken on next rising edge
                wait_left = -1;
                sink_checks++;
                if (delivered >= exp_q.size())
                begin
                    sink_errors++;
                    $display("error at %0t ns: target got %h with nothing pending",
                             $time, m_dat_w);
                end
                else if (m_adr != exp_adr || m_dat_w != exp_q[delivered] || !m_cyc || !m_we)
                begin
                    sink_errors++;
                    $display("error at %0t ns: target got %h at %h, expected %h at %h",
                             $time, m_dat_w, m_adr, exp_q[delivered], exp_adr);
                end
                delivered++;
                exp_adr++;                  // wraps at 256 like the DUT
            end
            else
                wait_left--;
        end
    end

    // run limit, set from the trace before the clock matters
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // trace player

    initial
    begin
        int                fd;
        string             line;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [DATA_W-1:0] rd;
        int                words;
        int                max_dly;

        void'($urandom(11989));
        s_cyc   = 1'b0;
        s_stb   = 1'b0;
        s_we    = 1'b0;
        s_adr   = '0;
        s_dat_w = '0;

        fd = $fopen("testbench/stream_trace.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open trace file testbench/stream_trace.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#")
                begin
                    a = '0;
                    b = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                    op_q.push_back(line[0]);
                    a_q.push_back(a);
                    b_q.push_back(b);
                end
            end
            $fclose(fd);
        end

        // words moved times slowest ack, plus per line overhead
        words   = 0;
        max_dly = 0;
        foreach (op_q[i])
        begin
            case (op_q[i])
                "W":     words += int'(b_q[i]);
                "B":     words += 1 + int'(b_q[i]);
                "R":     words += int'(a_q[i]);
                "X":     words += 1;
                "D":     max_dly = (int'(b_q[i]) > max_dly) ? int'(b_q[i]) : max_dly;
                default: words += 0;
            endcase
        end
        limit = 500 + 12 * op_q.size() + words * (max_dly + 8);

        @(negedge rst);
        foreach (op_q[i])
        begin
            a = a_q[i];
            b = b_q[i];
            case (op_q[i])
                "I":                        // idle bus after reset
                begin
                    checks++;
                    if (m_cyc || m_stb || s_ack)
                        flag_error("bus active after reset with no request");
                    close_test(int'(a));
                end
                "D":
                begin
                    dly_min = int'(a);
                    dly_max = int'(b);
                end
                "H": sink_hold <= a[0];
                "W":
                begin
                    for (int k = 0; k < int'(b); k++)
                        push_word(a + k, 0);    // counting pattern
                end
                "B": push_word(a, int'(b));
                "R":
                begin
                    repeat (a)
                        push_word($urandom, 0);
                end
                "S": read_status(int'(a), b[0]);
                "X": host_cycle(1'b1, REG_STATUS, a, 0, rd);   // no word queued
                "E":
                begin
                    wait_drained();
                    close_test(int'(a));
                end
                default: flag_error($sformatf("unknown trace op %c", op_q[i]));
            endcase
        end

        $display("tests %0d, checks %0d, failures %0d",
                 tests, checks + sink_checks, errors + sink_errors);
        if (errors + sink_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule : tb_stream_bridge

//--- testbench/stream_trace.txt
# op a b, hex fields, b optional
# W data n | B data stall | R n | X data | S count full | H hold | D min max | E test | I test
I 1
D 0 0
H 0
W a0000000 8
E 2
H 1
W b0000000 11
S 10 1
B b0000011 8
E 3
H 1
W c0000000 1
S 0 0
W c0000001 1
S 1 0
W c0000002 1
S 2 0
W c0000003 1
S 3 0
W c0000004 1
S 4 0
W c0000005 1
S 5 0
W c0000006 1
S 6 0
W c0000007 1
S 7 0
W c0000008 1
S 8 0
W c0000009 1
S 9 0
W c000000a 1
S a 0
W c000000b 1
S b 0
W c000000c 1
S c 0
W c000000d 1
S d 0
W c000000e 1
S e 0
W c000000f 1
S f 0
H 0
E 4
D 0 6
R 12c
E 5
D 0 3
X 5a5a5a5a
W d0000000 4
X 11111111
W d0000004 4
E 6

//--- flist.f
hdl/stream_pkg.sv
hdl/reg_fifo.sv
hdl/wb_push_port.sv
hdl/wb_drain_master.sv
hdl/stream_bridge_top.sv
testbench/tb_clock_gen.sv
testbench/tb_stream_bridge.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_stream_bridge
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log
PASS  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS)$$" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
